/* all.f */
common/isaPkg.sv
common/ctrlPkg.sv
source/alu.sv
source/regBlock.sv
datapath/datapath.sv
control/controlUnit.sv
source/cpuTop.sv
tests/cpuTop_properties.sv
tests/cpuTb.sv

/* run.sh */
#!/bin/sh
# build and run the cpu testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module cpuTb -o cpuSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/cpuSim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed!" "$log"; then
	exit 0
fi
echo "simulation reported failures"
exit 1

/* tests/program.hex */
// one instruction word per line, starting at address 0
// fields: op[15:11] rs2 or imm[10:6] rs1[5:3] rw[2:0]; address 40 holds data
37C7 // ldi r7, -1  port address
3141 // ldi r1, 5
30C2 // ldi r2, 3
008B // add r3, r1, r2
40F8 // st [r7], r3
0853 // sub r3, r2, r1  wraps below zero
40F8 // st [r7], r3
108B // and r3, r1, r2
40F8 // st [r7], r3
188B // or r3, r1, r2
40F8 // st [r7], r3
208B // xor r3, r1, r2
40F8 // st [r7], r3
41F8 // st [r7], r7
2F4C // addi r4, r1, -3
4138 // st [r7], r4
2A48 // addi r0, r1, 9
4038 // st [r7], r0
3285 // ldi r5, 10
016D // add r5, r5, r5
016D // add r5, r5, r5  r5 = 40
40E8 // st [r5], r3
382E // ld r6, [r5]
41B8 // st [r7], r6
084E // sub r6, r1, r1  zero
4840 // beq +1  taken
4078 // st [r7], r1  marker, skipped
088E // sub r6, r1, r2  non zero
4840 // beq +1  falls through
41B8 // st [r7], r6
2F6C // addi r4, r5, -3  subroutine at 37
5820 // call r4
40B8 // st [r7], r2  after return
2F2E // addi r6, r5, -4  halt at 36
5030 // jmp r6
4078 // st [r7], r1  marker, skipped
6800 // halt
4178 // st [r7], r5  subroutine body
6000 // ret

/* tests/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;

	localparam int numOut = 12;
	localparam int maxCycles = 2000; // 39 words at 4 cycles each, plenty of margin

	logic Clock;
	logic arstN;
	logic [isaPkg::dataWidth-1:0] outData;
	logic outValid;
	logic halted;

	logic [3:0] outIdx = '0; // strobes seen so far
	int errors = 0;
	int cycles = 0;

	// port values in program order, worked out by hand from the listing
	logic [isaPkg::dataWidth-1:0] expected [numOut] = '{
		16'h0008, // 5 + 3
		16'hFFFE, // 3 - 5 wraps
		16'h0001, // 5 & 3
		16'h0007, // 5 | 3
		16'h0006, // 5 ^ 3
		16'hFFFF, // ldi -1 sign extended
		16'h0002, // 5 + (-3)
		16'h0000, // r0 ignores the write
		16'h0006, // xor result back from address 40
		16'h0002, // 5 - 3, beq not taken
		16'h0028, // r5 from the subroutine
		16'h0003  // r2 at the return address
	};
	string names [numOut] = '{
		"add", "sub wrap", "and", "or", "xor", "ldi negative", "addi negative",
		"r0 write", "load after store", "beq fall through", "call subroutine",
		"after return"
	};

	cpuTop u_dut (
		.Clock    (Clock),
		.arstN    (arstN),
		.outData  (outData),
		.outValid (outValid),
		.halted   (halted)
	);

	always #5 Clock = ~Clock;

	initial begin
		Clock = 1'b0;
		arstN = 1'b0;
		repeat (3) @(posedge Clock);
		arstN <= 1'b1;
	end

	always @(posedge Clock) begin
		cycles <= cycles + 1;
		if (outValid) outIdx <= outIdx + 1'b1; // moves on at the end of the strobe cycle
	end

	// outputs are settled at the falling edge
	a_outValue: assert property (@(negedge Clock) disable iff (!arstN)
		outValid |-> outData == expected[outIdx])
		else begin
			errors = errors + 1;
			$display("FAILED %s expected %h actual %h", names[outIdx], expected[outIdx],
				outData);
		end

	a_outCount: assert property (@(negedge Clock) disable iff (!arstN)
		outValid |-> int'(outIdx) < numOut)
		else begin
			errors = errors + 1;
			$display("output strobe beyond the end of the expected sequence");
		end

	initial begin
		@(negedge Clock);
		while (!halted && cycles < maxCycles) @(negedge Clock);
		if (!halted) begin
			errors = errors + 1;
			$display("timeout: processor never halted");
		end
		repeat (2) @(negedge Clock); // a stray strobe would show here
		if (int'(outIdx) != numOut) begin
			errors = errors + 1;
			$display("saw %0d outputs but the program should give %0d", outIdx, numOut);
		end
		$display("errors %0d, outputs seen %0d of %0d", errors, outIdx, numOut);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* tests/cpuTop_properties.sv */
`timescale 1ns/1ps

module cpuTop_properties (
	input logic Clock,
	input logic arstN,
	input logic outValid,
	input logic halted
);

	// quiet in reset and on the first cycle out of it
	a_resetQuiet: assert property (@(posedge Clock) !arstN |-> !outValid)
		else $error("output strobe while reset is asserted");
	a_afterReset: assert property (@(posedge Clock) !arstN |=> !outValid)
		else $error("output strobe right after reset");

	a_haltSticky: assert property (@(posedge Clock) disable iff (!arstN) halted |=> halted)
		else $error("halted dropped without a reset");

	a_noStrobeHalted: assert property (@(posedge Clock) disable iff (!arstN) halted |-> !outValid)
		else $error("output strobe after the processor halted");

	// a store takes four cycles
	a_singleStrobe: assert property (@(posedge Clock) disable iff (!arstN) outValid |=> !outValid)
		else $error("output strobe held for two cycles");

endmodule

bind cpuTop cpuTop_properties u_properties (
	.Clock    (Clock),
	.arstN    (arstN),
	.outValid (outValid),
	.halted   (halted)
);

/* source/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop (
	input  logic Clock,
	input  logic arstN,
	output logic [isaPkg::dataWidth-1:0] outData,
	output logic outValid,
	output logic halted
);

	ctrlPkg::ctrl_t ctrl;
	isaPkg::opcode_t opcode;
	isaPkg::flags_t flags;
	logic [isaPkg::addrWidth-1:0] memAddr;
	logic [isaPkg::dataWidth-1:0] memRData, memWData;
	logic portHit;

	// unified program and data memory
	logic [isaPkg::dataWidth-1:0] mem [0:isaPkg::memDepth-1];

	initial $readmemh("tests/program.hex", mem);

	assign portHit = (memAddr == isaPkg::outPortAddr);

	always_ff @(posedge Clock) begin
		if (ctrl.memWe && !portHit) mem[memAddr] <= memWData;
	end

	assign memRData = mem[memAddr]; // asynchronous read

	// output port strobe, one cycle per store
	assign outValid = ctrl.memWe && portHit;
	assign outData = memWData;

	controlUnit u_controlUnit (
		.Clock  (Clock),
		.arstN  (arstN),
		.opcode (opcode),
		.flags  (flags),
		.ctrl   (ctrl),
		.halted (halted)
	);

	datapath u_datapath (
		.Clock    (Clock),
		.arstN    (arstN),
		.ctrl     (ctrl),
		.memRData (memRData),
		.memAddr  (memAddr),
		.memWData (memWData),
		.opcode   (opcode),
		.flags    (flags)
	);

endmodule

/* control/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
	input  logic Clock,
	input  logic arstN,
	input  isaPkg::opcode_t opcode,
	input  isaPkg::flags_t flags,
	output ctrlPkg::ctrl_t ctrl,
	output logic halted
);

	typedef enum logic [2:0] {Fetch, Decode, Execute, Writeback, Halt} state_t;

	state_t state, stateNext;
	isaPkg::alu_functions_t aluFunc;
	logic needsWb;

	// only results and memory ops take the fourth cycle
	assign needsWb = opcode inside {isaPkg::ADD, isaPkg::SUB, isaPkg::AND, isaPkg::OR,
		isaPkg::XOR, isaPkg::ADDI, isaPkg::LDI, isaPkg::LOAD, isaPkg::STORE};
	assign halted = (state == Halt);

	always_comb begin
		case (opcode)
			isaPkg::SUB: aluFunc = isaPkg::AluSub;
			isaPkg::AND: aluFunc = isaPkg::AluAnd;
			isaPkg::OR: aluFunc = isaPkg::AluOr;
			isaPkg::XOR: aluFunc = isaPkg::AluXor;
			isaPkg::LDI: aluFunc = isaPkg::AluPassB;
			default: aluFunc = isaPkg::AluAdd; // ADDI, address sums
		endcase
	end

	always_comb begin
		case (state)
			Fetch: stateNext = Decode;
			Decode: stateNext = Execute;
			Execute: begin
				if (opcode == isaPkg::HALT) stateNext = Halt;
				else if (needsWb) stateNext = Writeback;
				else stateNext = Fetch;
			end
			Writeback: stateNext = Fetch;
			default: stateNext = Halt; // stays until reset
		endcase
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) state <= Fetch;
		else state <= stateNext;
	end

	always_comb begin
		ctrl = ctrlPkg::ctrlNop; // decode and halt do nothing
		case (state)
			Fetch: begin
				ctrl.addrFromPc = 1'b1;
				ctrl.busSrc = ctrlPkg::BusMem;
				ctrl.irWe = 1'b1;
				ctrl.pcSel = ctrlPkg::Pc1;
				ctrl.pcWe = 1'b1;
			end
			Execute: begin
				ctrl.aluOp = aluFunc;
				case (opcode)
					isaPkg::ADD, isaPkg::SUB, isaPkg::AND, isaPkg::OR, isaPkg::XOR: begin
						ctrl.op2Sel = 1'b1;
						ctrl.aluWe = 1'b1;
					end
					isaPkg::ADDI, isaPkg::LDI: ctrl.aluWe = 1'b1;
					isaPkg::BEQ: begin
						ctrl.op1Sel = ctrlPkg::Op1Pc; // pc + imm, flags untouched
						ctrl.pcSel = ctrlPkg::PcAluOut;
						ctrl.pcWe = flags.Z;
					end
					isaPkg::JMP, isaPkg::CALL: begin
						ctrl.op2Sel = 1'b1; // rs1 + r0
						ctrl.pcSel = ctrlPkg::PcAluOut;
						ctrl.pcWe = 1'b1;
						ctrl.lrSel = 1'b1;
						ctrl.lrWe = (opcode == isaPkg::CALL);
					end
					isaPkg::RET: begin
						ctrl.pcSel = ctrlPkg::PcLr;
						ctrl.pcWe = 1'b1;
					end
					default: ;
				endcase
			end
			Writeback: begin
				case (opcode)
					isaPkg::LOAD: begin
						ctrl.busSrc = ctrlPkg::BusMem; // address from rs1
						ctrl.wdSel = 1'b1;
						ctrl.regWe = 1'b1;
					end
					isaPkg::STORE: begin
						ctrl.busSrc = ctrlPkg::BusRd2;
						ctrl.memWe = 1'b1;
					end
					default: ctrl.regWe = 1'b1;
				endcase
			end
			default: ;
		endcase
	end

endmodule

/* datapath/datapath.sv */
`timescale 1ns/1ps

module datapath (
	input  logic Clock,
	input  logic arstN,
	input  ctrlPkg::ctrl_t ctrl,
	input  logic [isaPkg::dataWidth-1:0] memRData,
	output logic [isaPkg::addrWidth-1:0] memAddr,
	output logic [isaPkg::dataWidth-1:0] memWData,
	output isaPkg::opcode_t opcode,
	output isaPkg::flags_t flags
);

	logic [isaPkg::dataWidth-1:0] pc, lr, ir, aluOut;
	logic [isaPkg::dataWidth-1:0] sysBus, pcIn, lrIn, wData;
	logic [isaPkg::dataWidth-1:0] op1, op2, immExt, rd1, rd2, aluRes;
	isaPkg::flags_t aluFlags;

	// immediate sign extended from bit 10
	assign immExt = {{(isaPkg::dataWidth - isaPkg::immWidth){ir[isaPkg::immLsb + isaPkg::immWidth - 1]}},
		ir[isaPkg::immLsb +: isaPkg::immWidth]};
	assign opcode = isaPkg::opcode_t'(ir[isaPkg::opLsb +: isaPkg::opcodeWidth]);

	// system bus as a plain mux
	always_comb begin
		case (ctrl.busSrc)
			ctrlPkg::BusMem: sysBus = memRData;
			ctrlPkg::BusAluOut: sysBus = aluOut;
			ctrlPkg::BusPc: sysBus = pc;
			default: sysBus = rd2;
		endcase
	end

	always_comb begin
		case (ctrl.pcSel)
			ctrlPkg::PcLr: pcIn = lr;
			ctrlPkg::PcAluOut: pcIn = aluRes; // branch and jump targets
			ctrlPkg::PcSysbus: pcIn = sysBus;
			default: pcIn = pc + 1'b1;
		endcase
	end

	assign op1 = (ctrl.op1Sel == ctrlPkg::Op1Pc) ? pc : rd1;
	assign op2 = ctrl.op2Sel ? rd2 : immExt;
	assign wData = ctrl.wdSel ? sysBus : aluOut;
	assign lrIn = ctrl.lrSel ? pc : sysBus; // return address on CALL

	assign memAddr = ctrl.addrFromPc ? pc[isaPkg::addrWidth-1:0] : rd1[isaPkg::addrWidth-1:0];
	assign memWData = rd2;

	regBlock u_regBlock (
		.Clock (Clock),
		.arstN (arstN),
		.We    (ctrl.regWe),
		.Rs1   (ir[isaPkg::rs1Lsb +: isaPkg::regAddrWidth]),
		.Rs2   (ir[isaPkg::rs2Lsb +: isaPkg::regAddrWidth]),
		.Rw    (ir[isaPkg::rwLsb +: isaPkg::regAddrWidth]),
		.WData (wData),
		.Rd1   (rd1),
		.Rd2   (rd2)
	);

	alu u_alu (
		.Op1    (op1),
		.Op2    (op2),
		.OpCode (ctrl.aluOp),
		.Result (aluRes),
		.Flags  (aluFlags)
	);

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			lr <= '0;
			ir <= '0;
			aluOut <= '0;
			flags <= '0;
		end else begin
			if (ctrl.pcWe) pc <= pcIn;
			if (ctrl.lrWe) lr <= lrIn;
			if (ctrl.irWe) ir <= sysBus;
			if (ctrl.aluWe) begin
				aluOut <= aluRes;
				flags <= aluFlags; // kept for a later BEQ
			end
		end
	end

endmodule

/* source/regBlock.sv */
`timescale 1ns/1ps

module regBlock (
	input  logic Clock,
	input  logic arstN,
	input  logic We,
	input  logic [isaPkg::regAddrWidth-1:0] Rs1,
	input  logic [isaPkg::regAddrWidth-1:0] Rs2,
	input  logic [isaPkg::regAddrWidth-1:0] Rw,
	input  logic [isaPkg::dataWidth-1:0] WData,
	output logic [isaPkg::dataWidth-1:0] Rd1,
	output logic [isaPkg::dataWidth-1:0] Rd2
);

	// r0 has no storage
	logic [isaPkg::dataWidth-1:0] regs [1:isaPkg::numRegs-1];

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < isaPkg::numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (We && Rw != '0) begin
			regs[Rw] <= WData;
		end
	end

	// two read ports, r0 reads zero
	assign Rd1 = (Rs1 == '0) ? '0 : regs[Rs1];
	assign Rd2 = (Rs2 == '0) ? '0 : regs[Rs2];

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
	input  logic [isaPkg::dataWidth-1:0] Op1,
	input  logic [isaPkg::dataWidth-1:0] Op2,
	input  isaPkg::alu_functions_t OpCode,
	output logic [isaPkg::dataWidth-1:0] Result,
	output isaPkg::flags_t Flags
);

	logic [isaPkg::dataWidth:0] wide; // one extra bit for carry out
	logic msb1, msb2, msbR;

	assign msb1 = Op1[isaPkg::dataWidth-1];
	assign msb2 = Op2[isaPkg::dataWidth-1];
	assign msbR = Result[isaPkg::dataWidth-1];

	always_comb begin
		wide = '0;
		Flags.C = 1'b0;
		Flags.V = 1'b0;
		case (OpCode)
			isaPkg::AluAdd: begin
				wide = {1'b0, Op1} + {1'b0, Op2};
				Flags.C = wide[isaPkg::dataWidth];
				Flags.V = (msb1 == msb2) && (msbR != msb1);
			end
			isaPkg::AluSub: begin
				wide = {1'b0, Op1} - {1'b0, Op2};
				Flags.C = wide[isaPkg::dataWidth]; // borrow
				Flags.V = (msb1 != msb2) && (msbR != msb1);
			end
			isaPkg::AluAnd: wide = {1'b0, Op1 & Op2};
			isaPkg::AluOr: wide = {1'b0, Op1 | Op2};
			isaPkg::AluXor: wide = {1'b0, Op1 ^ Op2};
			isaPkg::AluPassB: wide = {1'b0, Op2};
			default: wide = '0;
		endcase
		Flags.Z = (Result == '0);
		Flags.N = msbR;
	end

	assign Result = wide[isaPkg::dataWidth-1:0];

endmodule

/* common/ctrlPkg.sv */
package ctrlPkg;

	// next PC source
	typedef enum logic [1:0] {
		PcLr,
		PcAluOut, // the ALU result, for branch and jump targets
		PcSysbus,
		Pc1
	} pc_select_t;

	typedef enum logic {
		Op1Rd1,
		Op1Pc
	} op1_select_t;

	// which source drives SysBus
	typedef enum logic [1:0] {
		BusMem,
		BusAluOut,
		BusPc,
		BusRd2
	} bus_source_t;

	// one control word per cycle, decode to execute
	typedef struct packed {
		isaPkg::alu_functions_t aluOp;
		pc_select_t pcSel;
		op1_select_t op1Sel;
		bus_source_t busSrc;
		logic pcWe;
		logic irWe;
		logic aluWe;      // loads ALUOUT and flags
		logic lrWe;
		logic regWe;
		logic wdSel;      // 1 takes SysBus, 0 takes ALUOUT
		logic op2Sel;     // 1 takes Rd2, 0 the extended immediate
		logic lrSel;      // 1 takes PC, 0 takes SysBus
		logic memWe;
		logic addrFromPc; // else address is Rd1
	} ctrl_t;

	// idle word, nothing written
	localparam ctrl_t ctrlNop = '0;

endpackage

/* common/isaPkg.sv */
package isaPkg;

	// word and memory sizes
	localparam int dataWidth = 16;
	localparam int addrWidth = 8;
	localparam int memDepth = 1 << addrWidth;
	localparam logic [addrWidth-1:0] outPortAddr = 8'hFF; // stores here go to the output port

	// instruction fields, unused fields encode as zero
	localparam int opcodeWidth = 5;
	localparam int regAddrWidth = 3;
	localparam int numRegs = 1 << regAddrWidth;
	localparam int immWidth = 5;
	localparam int rwLsb = 0;   // write register
	localparam int rs1Lsb = 3;  // first source
	localparam int rs2Lsb = 6;  // second source
	localparam int immLsb = 6;  // overlaps rs2
	localparam int opLsb = 11;

	typedef enum logic [opcodeWidth-1:0] {
		ADD   = 5'd0,
		SUB   = 5'd1,
		AND   = 5'd2,
		OR    = 5'd3,
		XOR   = 5'd4,
		ADDI  = 5'd5,
		LDI   = 5'd6,
		LOAD  = 5'd7,
		STORE = 5'd8,
		BEQ   = 5'd9,  // offset relative to the already incremented PC
		JMP   = 5'd10, // target is rs1 + rs2, rs2 normally r0
		CALL  = 5'd11,
		RET   = 5'd12,
		HALT  = 5'd13
	} opcode_t;

	typedef enum logic [2:0] {AluAdd, AluSub, AluAnd, AluOr, AluXor, AluPassB} alu_functions_t;

	typedef struct packed {
		logic Z;
		logic N;
		logic C;
		logic V;
	} flags_t;

endpackage
